//--- Bender.yml
package:
  name: pattern_top

sources:
  - files:
      - source/video_pkg.sv
      - source/video_timing.sv
      - source/pattern_lane.sv
      - source/pixel_packer.sv
      - source/pattern_top.sv
  - target: test
    files:
      - bench/tb_pattern_top.sv

//--- bench/tb_pattern_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pattern_top;

    import video_pkg::*;

    // Small raster, 40 clocks per line, 20 lines per frame.
    localparam int LANES  = 2;
    localparam int H_ACT  = 64;
    localparam int H_FP   = 4;
    localparam int H_SYNC = 8;
    localparam int H_BP   = 4;
    localparam int V_ACT  = 16;
    localparam int V_FP   = 1;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 1;

    localparam int CLK_NS     = 100;
    localparam int LINE_CLKS  = (H_ACT + H_FP + H_SYNC + H_BP) / LANES;
    localparam int FRAME_CLKS = LINE_CLKS * (V_ACT + V_FP + V_SYNC + V_BP);
    localparam int BAR_W      = H_ACT / 8;
    // Mode changes are driven from this active line.
    localparam int CHG_LINE   = V_ACT / 2;
    localparam int RAND_STEPS = 4;
    // Sync frame, tests 1 to 4, then the random sequence.
    localparam int RUN_FRAMES = 6 + RAND_STEPS + 1;
    localparam int WATCH_NS   = (RUN_FRAMES + 2) * FRAME_CLKS * CLK_NS;
    localparam int unsigned SEED = 32'ha5e1a4a3;

    logic             pix_clk;
    logic             arst_n;
    pattern_e         pattern_mode;
    logic             vs;
    logic             hs;
    logic             de;
    rgb_t [LANES-1:0] pix_out;

    int          errors;
    int          checks;

    pattern_top #(
        .LANES  (LANES),
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP)
    ) i_dut (
        .pix_clk      (pix_clk),
        .arst_n       (arst_n),
        .pattern_mode (pattern_mode),
        .vs           (vs),
        .hs           (hs),
        .de           (de),
        .pix_out      (pix_out)
    );

    // 100 ns pixel clock.
    initial
    begin
        pix_clk = 1'b0;
        forever #(CLK_NS / 2) pix_clk = ~pix_clk;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_int(input int got, input int exp, input string what);
        checks++;
        assert (got == exp)
        else
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    // Each channel either full scale or off.
    function automatic rgb_t full_scale(input bit r, input bit g, input bit b);
        rgb_t p;
        p.r = r ? 8'hff : 8'h00;
        p.g = g ? 8'hff : 8'h00;
        p.b = b ? 8'hff : 8'h00;
        return p;
    endfunction

    // Reference pixel for an active column and line.
    function automatic rgb_t exp_pixel(input pattern_e mode, input int px, input int y);
        rgb_t p;
        p = full_scale(0, 0, 0);
        case (mode)
            PAT_WHITE:
                p = full_scale(1, 1, 1);
            PAT_BARS:
                case (px / BAR_W)
                    0: p = full_scale(1, 1, 1);
                    1: p = full_scale(1, 1, 0);
                    2: p = full_scale(0, 1, 1);
                    3: p = full_scale(0, 1, 0);
                    4: p = full_scale(1, 0, 1);
                    5: p = full_scale(1, 0, 0);
                    6: p = full_scale(0, 0, 1);
                    default: p = full_scale(0, 0, 0);
                endcase
            PAT_RAMP:
                p = '{r: 8'(px), g: 8'(px), b: 8'(px)};
            PAT_CHECKER:
                if (((px >> 3) & 1) != ((y >> 3) & 1))
                    p = full_scale(1, 1, 1);
            default:
                p = full_scale(0, 0, 0);
        endcase
        return p;
    endfunction

    // Returns on the falling edge where vs was first seen high.
    task automatic sync_frame();
        logic prev;
        logic found;
        prev  = vs;
        found = 1'b0;
        while (!found)
        begin
            @(negedge pix_clk);
            found = vs && !prev;
            prev  = vs;
        end
    endtask

    // One frame from vs rise to the next vs rise, raster and pixels.
    task automatic check_frame(input pattern_e mode, input logic chg_en,
                               input pattern_e chg_mode);
        int   frame_clks;
        int   line_clks;
        int   de_cnt;
        int   hs_len;
        int   vs_clks;
        int   act_lines;
        int   k;
        logic seen_hs;
        logic vs_prev;
        logic hs_prev;
        logic first;
        logic done;
        logic do_chg;
        rgb_t exp;
        frame_clks = 0;
        line_clks  = 0;
        de_cnt     = 0;
        hs_len     = 0;
        vs_clks    = 0;
        act_lines  = 0;
        seen_hs    = 1'b0;
        vs_prev    = 1'b0;
        hs_prev    = 1'b0;
        first      = 1'b1;
        done       = 1'b0;
        while (!done)
        begin
            if (!first)
            begin
                @(negedge pix_clk);
                done = vs && !vs_prev;
            end
            first = 1'b0;
            if (!done)
            begin
                // Line boundary.
                if (hs && !hs_prev)
                begin
                    if (seen_hs)
                        expect_int(line_clks, LINE_CLKS, "clocks per line");
                    if (de_cnt != 0)
                    begin
                        expect_int(de_cnt, H_ACT / LANES, "de clocks per line");
                        act_lines++;
                    end
                    seen_hs   = 1'b1;
                    line_clks = 0;
                    de_cnt    = 0;
                end
                if (!hs && hs_prev)
                begin
                    expect_int(hs_len, H_SYNC / LANES, "hs pulse clocks");
                    hs_len = 0;
                end
                for (k = 0; k < LANES; k++)
                begin
                    exp = de ? exp_pixel(mode, de_cnt * LANES + k, act_lines)
                             : full_scale(0, 0, 0);
                    checks++;
                    assert (pix_out[k] == exp)
                    else
                        report_mismatch($sformatf("lane %0d col %0d line %0d got %h, exp %h",
                            k, de_cnt * LANES + k, act_lines, pix_out[k], exp));
                end
                // Mid-frame, first group of the chosen line.
                do_chg = chg_en && de && (de_cnt == 0) && (act_lines == CHG_LINE);
                if (de)
                    de_cnt++;
                if (hs)
                    hs_len++;
                if (vs)
                    vs_clks++;
                line_clks++;
                frame_clks++;
                vs_prev = vs;
                hs_prev = hs;
                if (do_chg)
                begin
                    @(posedge pix_clk);
                    pattern_mode <= chg_mode;
                end
            end
        end
        expect_int(frame_clks, FRAME_CLKS, "clocks per frame");
        expect_int(vs_clks, V_SYNC * LINE_CLKS, "vs clocks per frame");
        expect_int(act_lines, V_ACT, "active lines per frame");
    endtask

    // Test 1.
    task automatic reset_and_raster();
        repeat (2)
        begin
            @(negedge pix_clk);
            checks++;
            assert (!vs && !hs && !de && pix_out == '0)
            else
                report_mismatch("outputs not idle and black during reset");
        end
        @(posedge pix_clk);
        arst_n <= 1'b1;
        sync_frame();
        check_frame(PAT_WHITE, 1'b0, PAT_WHITE);
    endtask

    // Test 2, then bars for the next frame.
    task automatic white_frame();
        check_frame(PAT_WHITE, 1'b1, PAT_BARS);
    endtask

    // Test 3.
    task automatic bars_frame();
        check_frame(PAT_BARS, 1'b1, PAT_RAMP);
    endtask

    // Test 4, both lanes of every group.
    task automatic ramp_checker_frames();
        check_frame(PAT_RAMP, 1'b1, PAT_CHECKER);
        check_frame(PAT_CHECKER, 1'b0, PAT_CHECKER);
    endtask

    // Test 5, old mode holds to the end of the frame.
    task automatic frame_aligned_switch();
        pattern_e cur;
        pattern_e next;
        cur = PAT_CHECKER;
        repeat (RAND_STEPS)
        begin
            // Always a different mode.
            next = pattern_e'((int'(cur) + 1 + ($urandom % 3)) % 4);
            check_frame(cur, 1'b1, next);
            cur = next;
        end
        check_frame(cur, 1'b0, cur);
    endtask

    initial
    begin
        arst_n       = 1'b0;
        pattern_mode = PAT_WHITE;
        errors       = 0;
        checks       = 0;
        void'($urandom(SEED));
        reset_and_raster();
        white_frame();
        bars_frame();
        ramp_checker_frames();
        frame_aligned_switch();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog.
    initial
    begin
        #(WATCH_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCH_NS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/video_pkg.sv
source/video_timing.sv
source/pattern_lane.sv
source/pixel_packer.sv
source/pattern_top.sv
bench/tb_pattern_top.sv

//--- source/pattern_lane.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_lane #(
    parameter int LANE  = 0,
    parameter int H_ACT = 1280
)(
    input  logic               pix_clk,
    input  logic               arst_n,
    input  video_pkg::timing_t tim,
    output video_pkg::rgb_t    pix
);

    import video_pkg::*;

    // Bar edges, each one eighth of the active width.
    localparam int BAR_W = H_ACT / 8;
    localparam int BAR_1 = 1 * BAR_W;
    localparam int BAR_2 = 2 * BAR_W;
    localparam int BAR_3 = 3 * BAR_W;
    localparam int BAR_4 = 4 * BAR_W;
    localparam int BAR_5 = 5 * BAR_W;
    localparam int BAR_6 = 6 * BAR_W;
    localparam int BAR_7 = 7 * BAR_W;

    // Channel full scale and off.
    localparam logic [COLOR_BITS-1:0] C_ON  = '1;
    localparam logic [COLOR_BITS-1:0] C_OFF = '0;

    logic [X_BITS-1:0] px;
    rgb_t              bar_pix;
    rgb_t              ramp_pix;
    rgb_t              check_pix;
    rgb_t              pix_nxt;

    // This lane's column inside the group.
    assign px = tim.x + X_BITS'(LANE);

    // Seven bars, black past the last one.
    always_comb
    begin
        if (px < BAR_1)
            bar_pix = '{r: C_ON,  g: C_ON,  b: C_ON};
        else if (px < BAR_2)
            bar_pix = '{r: C_ON,  g: C_ON,  b: C_OFF};
        else if (px < BAR_3)
            bar_pix = '{r: C_OFF, g: C_ON,  b: C_ON};
        else if (px < BAR_4)
            bar_pix = '{r: C_OFF, g: C_ON,  b: C_OFF};
        else if (px < BAR_5)
            bar_pix = '{r: C_ON,  g: C_OFF, b: C_ON};
        else if (px < BAR_6)
            bar_pix = '{r: C_ON,  g: C_OFF, b: C_OFF};
        else if (px < BAR_7)
            bar_pix = '{r: C_OFF, g: C_OFF, b: C_ON};
        else
            bar_pix = RGB_BLACK;
    end

    // Grey level wraps every 256 columns.
    assign ramp_pix = '{r: px[COLOR_BITS-1:0],
                        g: px[COLOR_BITS-1:0],
                        b: px[COLOR_BITS-1:0]};

    // 8x8 squares.
    assign check_pix = (px[3] ^ tim.y[3]) ? RGB_WHITE : RGB_BLACK;

    // Pattern select, black in blanking.
    always_comb
    begin
        pix_nxt = RGB_BLACK;
        if (tim.de)
        begin
            case (tim.mode)
                PAT_WHITE:   pix_nxt = RGB_WHITE;
                PAT_BARS:    pix_nxt = bar_pix;
                PAT_RAMP:    pix_nxt = ramp_pix;
                PAT_CHECKER: pix_nxt = check_pix;
                default:     pix_nxt = RGB_BLACK;
            endcase
        end
    end

    // One clock behind tim.
    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
            pix <= RGB_BLACK;
        else
            pix <= pix_nxt;
    end

    // Blanking paints black on the next clock.
    a_black_blank : assert property (@(posedge pix_clk) disable iff (!arst_n)
        !tim.de |=> (pix == RGB_BLACK));

    // Timing never hands a lane a column past the active width.
    a_px_range : assert property (@(posedge pix_clk) disable iff (!arst_n)
        tim.de |-> (px < H_ACT));

endmodule

`default_nettype wire

//--- source/pattern_top.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_top #(
    parameter int LANES  = 2,
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
)(
    input  logic                        pix_clk,
    input  logic                        arst_n,
    input  video_pkg::pattern_e         pattern_mode,
    output logic                        vs,
    output logic                        hs,
    output logic                        de,
    output video_pkg::rgb_t [LANES-1:0] pix_out
);

    import video_pkg::*;

    // Shared raster state for all lanes.
    timing_t              tim;
    // One painted pixel per lane.
    rgb_t [LANES-1:0]     lane_pix;

    video_timing #(
        .LANES  (LANES),
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP)
    ) i_timing (
        .pix_clk      (pix_clk),
        .arst_n       (arst_n),
        .pattern_mode (pattern_mode),
        .tim          (tim)
    );

    // Lane k paints column x + k.
    for (genvar k = 0; k < LANES; k++)
    begin : g_lane
        pattern_lane #(
            .LANE  (k),
            .H_ACT (H_ACT)
        ) i_lane (
            .pix_clk (pix_clk),
            .arst_n  (arst_n),
            .tim     (tim),
            .pix     (lane_pix[k])
        );
    end

    pixel_packer #(
        .LANES (LANES)
    ) i_packer (
        .pix_clk  (pix_clk),
        .arst_n   (arst_n),
        .tim      (tim),
        .lane_pix (lane_pix),
        .vs       (vs),
        .hs       (hs),
        .de       (de),
        .pix_out  (pix_out)
    );

endmodule

`default_nettype wire

//--- source/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_packer #(
    parameter int LANES = 2
)(
    input  logic                        pix_clk,
    input  logic                        arst_n,
    input  video_pkg::timing_t          tim,
    input  video_pkg::rgb_t [LANES-1:0] lane_pix,
    output logic                        vs,
    output logic                        hs,
    output logic                        de,
    output video_pkg::rgb_t [LANES-1:0] pix_out
);

    import video_pkg::*;

    // Syncs matched to the lane register.
    logic vs_d;
    logic hs_d;
    logic de_d;

    // First stage, same latency as the lanes.
    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vs_d <= 1'b0;
            hs_d <= 1'b0;
            de_d <= 1'b0;
        end
        else
        begin
            vs_d <= tim.vs;
            hs_d <= tim.hs;
            de_d <= tim.de;
        end
    end

    // Output stage, syncs and pixels together.
    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vs      <= 1'b0;
            hs      <= 1'b0;
            de      <= 1'b0;
            pix_out <= {LANES{RGB_BLACK}};
        end
        else
        begin
            vs      <= vs_d;
            hs      <= hs_d;
            de      <= de_d;
            pix_out <= lane_pix;
        end
    end

    // Lanes and syncs stay aligned, so blank output is black.
    a_blank_black : assert property (@(posedge pix_clk) disable iff (!arst_n)
        !de |-> (pix_out == {LANES{RGB_BLACK}}));

endmodule

`default_nettype wire

//--- source/video_pkg.sv
`default_nettype none

package video_pkg;

    // Bits per colour channel.
    localparam int COLOR_BITS = 8;

    // Column and line coordinate widths.
    localparam int X_BITS = 13;
    localparam int Y_BITS = 13;

    // Selectable test patterns.
    typedef enum logic [1:0] {
        PAT_WHITE   = 2'd0,
        PAT_BARS    = 2'd1,
        PAT_RAMP    = 2'd2,
        PAT_CHECKER = 2'd3
    } pattern_e;

    // One pixel, red in the top bits.
    typedef struct packed {
        logic [COLOR_BITS-1:0] r;
        logic [COLOR_BITS-1:0] g;
        logic [COLOR_BITS-1:0] b;
    } rgb_t;

    // Raster position and syncs for one group of pixels.
    typedef struct packed {
        logic              vs;
        logic              hs;
        logic              de;
        // Column of the first pixel in the group.
        logic [X_BITS-1:0] x;
        // Active line.
        logic [Y_BITS-1:0] y;
        // Pattern held for the whole frame.
        pattern_e          mode;
    } timing_t;

    // Blank and full-scale pixels.
    localparam rgb_t RGB_BLACK = '{r: '0, g: '0, b: '0};
    localparam rgb_t RGB_WHITE = '{r: '1, g: '1, b: '1};

    // Width of the timing struct.
    localparam int TIM_BITS = $bits(timing_t);

endpackage

`default_nettype wire

//--- source/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int LANES  = 2,
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
)(
    input  logic                pix_clk,
    input  logic                arst_n,
    input  video_pkg::pattern_e pattern_mode,
    output video_pkg::timing_t  tim
);

    import video_pkg::*;

    // Horizontal windows, counted in groups of LANES pixels.
    localparam int H_TOTAL = (H_ACT + H_FP + H_SYNC + H_BP) / LANES;
    localparam int H_ACT_G = H_ACT / LANES;
    localparam int HS_BEG  = (H_ACT + H_FP) / LANES;
    localparam int HS_END  = (H_ACT + H_FP + H_SYNC) / LANES;

    // Vertical windows, counted in lines.
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;
    localparam int VS_BEG  = V_ACT + V_FP;
    localparam int VS_END  = V_ACT + V_FP + V_SYNC;

    // Group column and line counters.
    logic [X_BITS-1:0] h_cnt;
    logic [Y_BITS-1:0] v_cnt;
    logic              h_last;
    logic              v_last;
    logic              frame_start;
    timing_t           tim_nxt;

    // Every horizontal value must split evenly into groups.
    if ((H_ACT % LANES) != 0 || (H_FP % LANES) != 0 ||
        (H_SYNC % LANES) != 0 || (H_BP % LANES) != 0)
    begin : g_bad_lanes
        $error("video_timing: horizontal timing is not a multiple of LANES");
    end

    assign h_last      = (h_cnt == X_BITS'(H_TOTAL - 1));
    assign v_last      = (v_cnt == Y_BITS'(V_TOTAL - 1));
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    // Column wraps each line, line wraps each frame.
    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Window decode from the counters.
    always_comb
    begin
        tim_nxt.vs = (v_cnt >= VS_BEG) && (v_cnt < VS_END);
        tim_nxt.hs = (h_cnt >= HS_BEG) && (h_cnt < HS_END);
        tim_nxt.de = (h_cnt < H_ACT_G) && (v_cnt < V_ACT);
        // First pixel of the group.
        tim_nxt.x  = X_BITS'(h_cnt * LANES);
        tim_nxt.y  = v_cnt;
        // New mode only on the first group of line 0, so a frame never tears.
        tim_nxt.mode = frame_start ? pattern_mode : tim.mode;
    end

    // One clock behind the counters.
    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
            tim <= '{vs: 1'b0, hs: 1'b0, de: 1'b0, x: '0, y: '0, mode: PAT_WHITE};
        else
            tim <= tim_nxt;
    end

    // Active video never overlaps horizontal sync.
    a_hs_not_de : assert property (@(posedge pix_clk) disable iff (!arst_n)
        !(tim.hs && tim.de));

    // Active video never overlaps vertical sync.
    a_de_not_vs : assert property (@(posedge pix_clk) disable iff (!arst_n)
        tim.de |-> !tim.vs);

endmodule

`default_nettype wire
